//--- compile.f
+incdir+design
design/result_pkg.sv
design/signature_pkg.sv
design/result_fold.sv
design/reduce_level.sv
design/result_signature.sv
dv/result_signature_tb.sv

//--- design/reduce_level.sv
`default_nettype none

`include "sig_settings.svh"

module reduce_level
#(
    parameter int n_in = 8
)
(
    input  logic                                         ap_clk,
    input  logic                                         rst_n,
    input  signature_pkg::partial_sig_t [n_in-1:0]       sig_in,
    output signature_pkg::partial_sig_t [n_in/2-1:0]     sig_out
);

    localparam int n_out = n_in / 2;

    signature_pkg::partial_sig_t [n_out-1:0] sig_nxt;

    // pairs only, an odd input would be dropped silently
    if (n_in % 2 != 0)
    begin : g_bad_width
        $error("reduce_level needs an even input count, got %0d", n_in);
    end

    // ####################
    // pairwise select/xor
    // ####################

    // inputs 2j and 2j+1 merge into output j
    always_comb
    begin
        for (int j = 0; j < n_out; j++)
        begin
            sig_nxt[j].valid = sig_in[2*j].valid | sig_in[2*j+1].valid;
            case ({sig_in[2*j+1].valid, sig_in[2*j].valid})
                2'b01:
                begin
                    sig_nxt[j].data = sig_in[2*j].data;
                end
                2'b10:
                begin
                    sig_nxt[j].data = sig_in[2*j+1].data;
                end
                2'b11:
                begin
                    sig_nxt[j].data = sig_in[2*j].data ^ sig_in[2*j+1].data;
                end
                default:
                begin
                    sig_nxt[j].data = '0;
                end
            endcase
        end
    end

    always_ff @(posedge ap_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sig_out <= '0;
        end
        else
        begin
            sig_out <= sig_nxt;
        end
    end

    // ####################
    // output checks
    // ####################

    // idle outputs must be clean so that a later xor is not disturbed,
    // even though the fold stage passes ungated bytes
    for (genvar j = 0; j < n_out; j++)
    begin : g_out_chk
        a_idle_zero: assert property (
            @(posedge ap_clk) disable iff (!rst_n)
            !sig_out[j].valid |-> (sig_out[j].data == '0)
        )
        else
        begin
            $error("idle output %0d carries data %h", j, sig_out[j].data);
        end
    end

endmodule

`default_nettype wire

//--- design/result_fold.sv
`default_nettype none

`include "sig_settings.svh"

module result_fold
(
    input  logic                                             ap_clk,
    input  logic                                             rst_n,
    input  result_pkg::result_bus_t                          lanes,
    output signature_pkg::partial_sig_t [`SIG_LANES-1:0]     folded
);

    localparam int word_bytes = `SIG_WORD_W / `SIG_BYTE_W;

    signature_pkg::partial_sig_t [`SIG_LANES-1:0] fold_nxt;

    // ####################
    // byte fold per lane
    // ####################

    // xor of all bytes of one word
    function automatic logic [`SIG_BYTE_W-1:0] fold_word
    (
        input result_pkg::result_word_t w
    );
        logic [`SIG_BYTE_W-1:0] acc;
        acc = '0;
        for (int b = 0; b < word_bytes; b++)
        begin
            acc = acc ^ w[b];
        end
        return acc;
    endfunction

    // payload is folded even for idle lanes, the tree does the gating
    always_comb
    begin
        for (int i = 0; i < `SIG_LANES; i++)
        begin
            fold_nxt[i].valid = lanes[i].valid;
            fold_nxt[i].data  = fold_word(lanes[i].word);
        end
    end

    always_ff @(posedge ap_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            folded <= '0;
        end
        else
        begin
            folded <= fold_nxt;
        end
    end

    // ####################
    // input checks
    // ####################

    // an X strobe would poison the valid chain of the whole tree
    for (genvar i = 0; i < `SIG_LANES; i++)
    begin : g_lane_chk
        a_strobe_known: assert property (
            @(posedge ap_clk) disable iff (!rst_n)
            !$isunknown(lanes[i].valid)
        )
        else
        begin
            $error("lane %0d write strobe is unknown", i);
        end
    end

endmodule

`default_nettype wire

//--- design/result_pkg.sv
`default_nettype none

`include "sig_settings.svh"

package result_pkg;

    // ####################
    // kernel result lanes
    // ####################

    // one result word viewed as its bytes, byte 0 is bits 7:0
    typedef logic [`SIG_WORD_W/`SIG_BYTE_W-1:0][`SIG_BYTE_W-1:0] result_word_t;

    // write strobe plus payload, one per lane
    typedef struct packed {
        logic         valid;
        result_word_t word;
    } result_lane_t;

    // all lanes presented in the same cycle
    typedef result_lane_t [`SIG_LANES-1:0] result_bus_t;

endpackage

`default_nettype wire

//--- design/result_signature.sv
`default_nettype none

`include "sig_settings.svh"

module result_signature
(
    input  logic                       ap_clk,
    input  logic                       rst_n,
    input  result_pkg::result_bus_t    lanes,
    output logic [`SIG_NIBBLE_W-1:0]   data_out,
    output logic                       data_valid
);

    // lanes left after the last tree level
    localparam int tree_out = `SIG_LANES >> `SIG_LEVELS;

    signature_pkg::partial_sig_t [`SIG_LANES-1:0]   fold_sig;
    signature_pkg::partial_sig_t [`SIG_LANES/2-1:0] lvl0_sig;
    signature_pkg::partial_sig_t [`SIG_LANES/4-1:0] lvl1_sig;
    signature_pkg::partial_sig_t [tree_out-1:0]     lvl2_sig;
    signature_pkg::out_sig_t                        out_q;

    // three explicit levels below must end in one lane
    if (tree_out != 1)
    begin : g_bad_depth
        $error("tree depth %0d does not match %0d lanes", `SIG_LEVELS, `SIG_LANES);
    end

    // ####################
    // fold and tree
    // ####################

    result_fold u_fold
    (
        .ap_clk (ap_clk),
        .rst_n  (rst_n),
        .lanes  (lanes),
        .folded (fold_sig)
    );

    reduce_level #(.n_in(`SIG_LANES)) u_level0
    (
        .ap_clk  (ap_clk),
        .rst_n   (rst_n),
        .sig_in  (fold_sig),
        .sig_out (lvl0_sig)
    );

    reduce_level #(.n_in(`SIG_LANES/2)) u_level1
    (
        .ap_clk  (ap_clk),
        .rst_n   (rst_n),
        .sig_in  (lvl0_sig),
        .sig_out (lvl1_sig)
    );

    reduce_level #(.n_in(`SIG_LANES/4)) u_level2
    (
        .ap_clk  (ap_clk),
        .rst_n   (rst_n),
        .sig_in  (lvl1_sig),
        .sig_out (lvl2_sig)
    );

    // ####################
    // nibble fold
    // ####################

    // tree byte is already zero when idle, no extra gating needed
    always_ff @(posedge ap_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_q <= '0;
        end
        else
        begin
            out_q.valid  <= lvl2_sig[0].valid;
            out_q.nibble <= lvl2_sig[0].data[`SIG_BYTE_W-1:`SIG_NIBBLE_W]
                          ^ lvl2_sig[0].data[`SIG_NIBBLE_W-1:0];
        end
    end

    assign data_out   = out_q.nibble;
    assign data_valid = out_q.valid;

    // masking through all levels has to leave a quiet output
    a_out_idle_zero: assert property (
        @(posedge ap_clk) disable iff (!rst_n)
        !data_valid |-> (data_out == '0)
    )
    else
    begin
        $error("data_out %h while data_valid is low", data_out);
    end

endmodule

`default_nettype wire

//--- design/sig_settings.svh
`ifndef SIG_SETTINGS_SVH
`define SIG_SETTINGS_SVH

// ####################
// result lane geometry
// ####################

// number of kernel result lanes
`define SIG_LANES 8

// one result word per lane
`define SIG_WORD_W 32

// each word folds down to one byte
`define SIG_BYTE_W 8

// signature output width
`define SIG_NIBBLE_W 4

// pairwise tree depth, log2 of lane count
`define SIG_LEVELS 3

`endif

//--- design/signature_pkg.sv
`default_nettype none

`include "sig_settings.svh"

package signature_pkg;

    // ####################
    // signature tree types
    // ####################

    // folded byte between tree levels
    typedef struct packed {
        logic                   valid;
        logic [`SIG_BYTE_W-1:0] data;
    } partial_sig_t;

    // final registered signature
    typedef struct packed {
        logic                     valid;
        logic [`SIG_NIBBLE_W-1:0] nibble;
    } out_sig_t;

endpackage

`default_nettype wire

//--- dv/result_signature_tb.sv
`default_nettype none

`include "sig_settings.svh"

module result_signature_tb;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int pipe_depth   = 5;
    localparam int gap_cycles   = pipe_depth + 1;
    localparam int idle_cycles  = 4;
    localparam int all_sets     = 4;
    localparam int mask_sets    = 60;
    localparam int burst_sets   = 300;
    localparam int total_cycles = reset_cycles + 1 + idle_cycles
                                + `SIG_LANES * (1 + gap_cycles)
                                + all_sets * (1 + gap_cycles)
                                + mask_sets + gap_cycles
                                + burst_sets + gap_cycles + 1;

    logic                      ap_clk;
    logic                      rst_n;
    result_pkg::result_bus_t   lanes;
    logic [`SIG_NIBBLE_W-1:0]  data_out;
    logic                      data_valid;

    integer seed;
    int     error_count;
    int     reset_edges;
    string  cur_name;

    // expected {valid, nibble} of every set inside the pipeline
    logic [`SIG_NIBBLE_W:0] exp_q[$];
    string                  name_q[$];

    result_signature dut
    (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .lanes      (lanes),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    always #(clk_period / 2) ap_clk = ~ap_clk;

    // ####################
    // reference and checks
    // ####################

    // xor of the byte folds of all valid lanes folded down to one nibble
    function automatic logic [`SIG_NIBBLE_W:0] expected_sig
    (
        input result_pkg::result_bus_t bus
    );
        logic [`SIG_BYTE_W-1:0] acc;
        logic [`SIG_WORD_W-1:0] w;
        logic                   any_valid;
        acc = '0;
        any_valid = 1'b0;
        for (int i = 0; i < `SIG_LANES; i++)
        begin
            if (bus[i].valid)
            begin
                w = bus[i].word;
                acc = acc ^ w[7:0] ^ w[15:8] ^ w[23:16] ^ w[31:24];
                any_valid = 1'b1;
            end
        end
        return {any_valid, acc[7:4] ^ acc[3:0]};
    endfunction

    task automatic check_value
    (
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // outputs read at the rising edge still hold the previous cycle's result
    always @(posedge ap_clk)
    begin : compare_outputs
        logic [`SIG_NIBBLE_W:0] exp_sig;
        string                  exp_name;
        if (!rst_n)
        begin
            if (reset_edges > 0)
            begin
                check_value("reset data_valid", 32'd0, 32'(data_valid));
                check_value("reset data_out", 32'd0, 32'(data_out));
            end
            reset_edges++;
        end
        else
        begin
            exp_sig = exp_q.pop_front();
            exp_name = name_q.pop_front();
            check_value({exp_name, " data_valid"}, 32'(exp_sig[`SIG_NIBBLE_W]),
                        32'(data_valid));
            check_value({exp_name, " data_out"}, 32'(exp_sig[`SIG_NIBBLE_W-1:0]),
                        32'(data_out));
            exp_q.push_back(expected_sig(lanes));
            name_q.push_back(cur_name);
        end
    end

    // ####################
    // stimulus
    // ####################

    task automatic drive_set
    (
        input string                                  name,
        input logic [`SIG_LANES-1:0]                  mask,
        input logic [`SIG_LANES-1:0][`SIG_WORD_W-1:0] words
    );
        @(negedge ap_clk);
        cur_name = name;
        for (int i = 0; i < `SIG_LANES; i++)
        begin
            lanes[i].valid = mask[i];
            lanes[i].word  = words[i];
        end
    endtask

    task automatic drive_idle
    (
        input string name,
        input int    cycles
    );
        repeat (cycles)
        begin
            @(negedge ap_clk);
            cur_name = name;
            lanes = '0;
        end
    endtask

    task automatic fill_random_words
    (
        output logic [`SIG_LANES-1:0][`SIG_WORD_W-1:0] words
    );
        for (int i = 0; i < `SIG_LANES; i++)
        begin
            words[i] = $random(seed);
        end
    endtask

    initial
    begin
        logic [`SIG_LANES-1:0][`SIG_WORD_W-1:0] words;
        logic [`SIG_LANES-1:0]                  mask;
        seed = 54997;
        error_count = 0;
        reset_edges = 0;
        ap_clk = 1'b0;
        rst_n = 1'b0;
        lanes = '0;
        cur_name = "reset";
        // pipeline holds idle results right out of reset
        for (int i = 0; i < pipe_depth; i++)
        begin
            exp_q.push_back('0);
            name_q.push_back("reset");
        end

        repeat (reset_cycles) @(posedge ap_clk);
        @(negedge ap_clk);
        rst_n = 1'b1;
        drive_idle("reset", idle_cycles);

        // each lane alone with an idle gap so the latency is seen in isolation
        for (int i = 0; i < `SIG_LANES; i++)
        begin
            words = '0;
            words[i] = 32'h1357_9bdf ^ (i + 1);
            drive_set("single_lane", 8'(1 << i), words);
            drive_idle("single_lane", gap_cycles);
        end

        for (int s = 0; s < all_sets; s++)
        begin
            if (s == 0)
            begin
                for (int i = 0; i < `SIG_LANES; i++)
                begin
                    words[i] = 32'hcafe_0000 | (i * 32'h0011_0203);
                end
            end
            else
            begin
                fill_random_words(words);
            end
            drive_set("all_lanes", '1, words);
            drive_idle("all_lanes", gap_cycles);
        end

        // first set is all-invalid with random payload
        for (int s = 0; s < mask_sets; s++)
        begin
            fill_random_words(words);
            mask = (s == 0) ? '0 : 8'($random(seed));
            drive_set("masking", mask, words);
        end
        drive_idle("masking", gap_cycles);

        for (int s = 0; s < burst_sets; s++)
        begin
            fill_random_words(words);
            mask = 8'($random(seed));
            drive_set("back_to_back", mask, words);
        end
        drive_idle("back_to_back", gap_cycles);

        @(negedge ap_clk);
        if (error_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    initial
    begin
        #((total_cycles + 20) * clk_period);
        $display("watchdog expired, the run did not end within %0d cycles", total_cycles + 20);
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the result signature testbench with Verilator.
# The run counts as failed when the log holds the fail message.

cd "$(dirname "$0")" || exit 1

top=result_signature_tb
log=sim.log

echo "building $top"
verilator --binary --timing --assert \
    -f compile.f \
    --top-module "$top" \
    -o "$top"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

if [ ! -x "obj_dir/$top" ]; then
    echo "simulation binary obj_dir/$top is missing"
    exit 1
fi

echo "running $top"
"./obj_dir/$top" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Test failed" "$log"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if ! grep -q "Test completed successfully" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
exit 0
